// ==== project.f ====
verilog/game_pkg.sv
verilog/unit_spawner.sv
verilog/unit_slot.sv
verilog/tower_keeper.sv
verilog/game_engine.sv
verification/game_engine_checker.sv
verification/game_monitor.sv
verification/tb_game_engine.sv

// ==== Bender.yml ====
package:
  name: game_engine

sources:
  - files:
      - verilog/game_pkg.sv
      - verilog/unit_spawner.sv
      - verilog/unit_slot.sv
      - verilog/tower_keeper.sv
      - verilog/game_engine.sv
  - target: test
    files:
      - verification/game_engine_checker.sv
      - verification/game_monitor.sv
      - verification/tb_game_engine.sv

// ==== verification/tb_game_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_game_engine;
    import game_pkg::*;

    localparam int NUM_SLOTS = 8;

    logic                 clk_25MHz = 1'b0;
    logic                 rst;
    logic                 tick;
    logic                 spawn;
    unit_kind_t           spawn_kind;
    logic                 fire;
    logic [NUM_SLOTS-1:0] alive;
    logic [7:0]           charge;
    logic [11:0]          tower_hp;
    logic                 game_lose;
    logic [1:0]           tick_div = 2'd0;
    logic [31:0]          rng = 32'hd762;
    int                   test_id = 0;
    int                   errors;
    int                   timeouts = 0;

    always #20 clk_25MHz = ~clk_25MHz;

    // one game tick every four clocks
    always @(posedge clk_25MHz) begin
        tick_div <= rst ? 2'd0 : tick_div + 2'd1;
        tick     <= !rst && (tick_div == 2'd3);
    end

    game_engine #(.NUM_SLOTS(NUM_SLOTS), .TOWER_HP(12'd600)) i_game_engine (.*);
    game_monitor #(.NUM_SLOTS(NUM_SLOTS), .TOWER_HP(12'd600)) i_game_monitor (.*);
    bind game_engine game_engine_checker #(.NUM_SLOTS(NUM_SLOTS)) i_game_engine_checker (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic logic goal_met(input int goal);
        case (goal)
            0: return charge == CHARGE_MAX;
            1: return alive != '1;
            default: return game_lose;
        endcase
    endfunction

    // random weak shots only while waiting for a full cannon
    task automatic wait_until(input int goal, input string what);
        int n;
        n = 0;
        while (!goal_met(goal)) begin
            @(posedge clk_25MHz);
            rng = xorshift(rng);
            fire <= (goal == 0) && (charge < 8'd140) && (rng[3:0] == 4'd0);
            n++;
            if (n == 20000) begin
                $display("timeout while waiting for %s", what);
                timeouts++;
                break;
            end
        end
    endtask

    initial begin
        rst        = 1'b1;
        tick       = 1'b0;
        spawn      = 1'b0;
        spawn_kind = killer_bird;
        fire       = 1'b0;
        repeat (4) @(posedge clk_25MHz);
        rst <= 1'b0;
        repeat (3) @(posedge clk_25MHz);

        // --------------------------------------------------
        // fill the lane, ninth spawn is dropped
        // --------------------------------------------------
        test_id = 1;
        for (int i = 0; i < 9; i++) begin
            rng = xorshift(rng);
            repeat (1 + rng[1:0]) @(posedge clk_25MHz);
            spawn      <= 1'b1;
            spawn_kind <= (i < 2) ? killer_bird : unit_kind_t'(rng[9:8]);
            @(posedge clk_25MHz);
            spawn <= 1'b0;
        end

        test_id = 2;
        wait_until(0, "the cannon to reach full charge");
        repeat (16) @(posedge clk_25MHz);   // ticks at full charge, charge holds
        test_id = 3;
        fire <= 1'b1;
        wait_until(1, "a slot to be freed by the cannon");

        test_id = 4;   // reuse of the freed slot
        rng = xorshift(rng);
        spawn      <= 1'b1;
        spawn_kind <= unit_kind_t'(rng[9:8]);
        @(posedge clk_25MHz);
        spawn <= 1'b0;

        test_id = 5;
        wait_until(2, "game_lose to rise");
        repeat (200) @(posedge clk_25MHz);

        $display("errors: %0d mismatches, %0d assertion failures, %0d timeouts",
                 errors, i_game_engine.i_game_engine_checker.failures, timeouts);
        if (errors == 0 && timeouts == 0
            && i_game_engine.i_game_engine_checker.failures == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/game_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module game_monitor #(
    parameter int          NUM_SLOTS = 8,
    parameter logic [11:0] TOWER_HP  = 12'd4000
) (
    input  logic                 clk_25MHz,
    input  logic                 rst,
    input  logic                 tick,
    input  logic                 spawn,
    input  game_pkg::unit_kind_t spawn_kind,
    input  logic                 fire,
    input  logic [NUM_SLOTS-1:0] alive,
    input  logic [7:0]           charge,
    input  logic [11:0]          tower_hp,
    input  logic                 game_lose,
    input  int                   test_id,
    output int                   errors
);
    import game_pkg::*;

    logic [NUM_SLOTS-1:0] m_alive;
    logic [NUM_SLOTS-1:0] m_hit;
    logic                 m_repel;
    unit_kind_t           m_kind [NUM_SLOTS];
    unit_state_t          m_state [NUM_SLOTS];
    int                   m_x [NUM_SLOTS];
    int                   m_hp [NUM_SLOTS];
    int                   m_phase [NUM_SLOTS];
    int                   m_dmg [NUM_SLOTS];
    int                   m_tower;
    int                   m_charge;

    function automatic void reset_model();
        m_alive  = '0;
        m_hit    = '0;
        m_repel  = 1'b0;
        m_tower  = TOWER_HP;
        m_charge = 0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            m_kind[i]  = killer_bird;
            m_state[i] = st_move;
            m_phase[i] = 0;
            m_x[i]     = 0;
            m_hp[i]    = 0;
            m_dmg[i]   = 0;
        end
    endfunction

    // --------------------------------------------------
    // reference model, one clock edge
    // --------------------------------------------------
    function automatic void step_model(input logic tk, input logic sp,
                                       input unit_kind_t sk, input logic fr);
        unit_stats_t st;
        int          free_slot;
        int          dmg;
        logic        shot;
        free_slot = -1;
        dmg       = 0;
        shot      = m_repel;   // slots see last cycle's shot
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (sp && !m_alive[i]) free_slot = i;   // lowest free wins
            if (m_hit[i]) dmg += m_dmg[i];
        end
        m_tower  = (dmg >= m_tower) ? 0 : m_tower - dmg;
        m_repel  = fr && (m_charge == CHARGE_MAX);
        m_charge = m_repel ? 0 : ((tk && m_charge < CHARGE_MAX) ? m_charge + 1 : m_charge);
        for (int i = 0; i < NUM_SLOTS; i++) begin
            m_hit[i] = 1'b0;
            if (i == free_slot) begin
                st         = enemy_stats(sk);
                m_alive[i] = 1'b1;
                m_kind[i]  = sk;
                m_state[i] = st_move;
                m_phase[i] = 0;
                m_x[i]     = SPAWN_X;
                m_hp[i]    = st.hp;
            end else if (shot && m_alive[i] && m_x[i] > REPEL_X) begin
                m_state[i] = st_repel;
                m_phase[i] = 0;
                m_alive[i] = m_hp[i] > FIRE_DAMAGE;
                m_hp[i]    = m_hp[i] - FIRE_DAMAGE;
            end else if (tk && m_alive[i]) begin
                st = enemy_stats(m_kind[i]);
                case (m_state[i])
                    st_move: begin
                        if (m_x[i] + st.range >= TOWER_X) begin
                            m_state[i] = st_atk_0;
                            m_phase[i] = 0;
                        end else begin
                            m_x[i] = m_x[i] + st.speed;
                        end
                    end
                    st_atk_1: begin
                        m_hit[i]   = 1'b1;
                        m_dmg[i]   = st.atk;
                        m_state[i] = st_atk_2;
                        m_phase[i] = 0;
                    end
                    st_repel: begin
                        if (m_phase[i] == REPEL_TICKS) begin
                            m_state[i] = st_move;
                            m_phase[i] = 0;
                        end else begin
                            m_phase[i] = m_phase[i] + 1;
                            m_x[i]     = m_x[i] - REPEL_STEP;
                        end
                    end
                    default: begin   // waiting phases
                        if (m_phase[i] == st.cooldown) begin
                            m_phase[i] = 0;
                            if (m_state[i] == st_atk_0) m_state[i] = st_atk_1;
                            else if (m_state[i] == st_atk_2) m_state[i] = st_atk_3;
                            else m_state[i] = st_move;
                        end else begin
                            m_phase[i] = m_phase[i] + 1;
                        end
                    end
                endcase
            end
        end
    endfunction

    function automatic string test_name(input int id);
        case (id)
            0: return "reset";
            1: return "spawning";
            2: return "move_attack_charge";
            3: return "cannon";
            4: return "death";
            default: return "defeat";
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Error %s %s: expected %0d, actual %0d", test_name(test_id), what, exp, act);
            errors++;
        end
    endtask

    initial errors = 0;

    always @(posedge clk_25MHz or posedge rst) begin
        if (rst) begin
            reset_model();
        end else begin
            step_model(tick, spawn, spawn_kind, fire);
        end
    end

    // outputs are settled by the falling edge
    always @(negedge clk_25MHz) begin
        if (rst == 1'b0) begin
            check_value("alive", m_alive, alive);
            check_value("charge", m_charge, charge);
            check_value("tower_hp", m_tower, tower_hp);
            check_value("game_lose", m_tower == 0, game_lose);
        end
    end

endmodule

`default_nettype wire

// ==== verification/game_engine_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module game_engine_checker #(
    parameter int NUM_SLOTS = 8
) (
    input logic                 clk_25MHz,
    input logic                 rst,
    input logic                 fire,
    input logic                 repel,
    input logic [NUM_SLOTS-1:0] load,
    input logic [7:0]           charge,
    input logic [11:0]          tower_hp,
    input logic                 game_lose
);
    import game_pkg::*;

    int failures = 0;

    load_onehot: assert property (@(posedge clk_25MHz) disable iff (rst) $onehot0(load))
    else begin
        $error("spawner raised more than one load bit");
        failures++;
    end

    // a fallen tower stays at zero with the flag up
    lose_flag: assert property (@(posedge clk_25MHz) disable iff (rst)
        (tower_hp == 12'd0) |-> game_lose ##1 (game_lose && tower_hp == 12'd0))
    else begin
        $error("game_lose or tower_hp left the lost state");
        failures++;
    end

    // a cannon that is not full must not shoot
    weak_fire: assert property (@(posedge clk_25MHz) disable iff (rst)
        (fire && charge != CHARGE_MAX) |=> !repel)
    else begin
        $error("repel followed a fire below full charge");
        failures++;
    end

endmodule

`default_nettype wire

// ==== verilog/game_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module game_engine #(
    parameter int          NUM_SLOTS = 8,
    parameter logic [11:0] TOWER_HP  = 12'd4000
) (
    input  logic                 clk_25MHz,
    input  logic                 rst,
    input  logic                 tick,
    input  logic                 spawn,
    input  game_pkg::unit_kind_t spawn_kind,
    input  logic                 fire,
    output logic [NUM_SLOTS-1:0] alive,
    output logic [7:0]           charge,
    output logic [11:0]          tower_hp,
    output logic                 game_lose
);

    logic [NUM_SLOTS-1:0] load;   // one-hot
    logic [NUM_SLOTS-1:0] hit;
    logic [8:0]           hit_dmg [NUM_SLOTS];
    logic                 repel;   // cannon shot, broadcast

    unit_spawner #(
        .NUM_SLOTS (NUM_SLOTS)
    ) i_unit_spawner (
        .spawn (spawn),
        .alive (alive),
        .load  (load)
    );

    // --------------------------------------------------
    // enemy lane
    // --------------------------------------------------
    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
        unit_slot i_unit_slot (
            .clk_25MHz  (clk_25MHz),
            .rst        (rst),
            .tick       (tick),
            .load       (load[i]),
            .spawn_kind (spawn_kind),
            .repel      (repel),
            .alive      (alive[i]),
            .hit        (hit[i]),
            .hit_dmg    (hit_dmg[i])
        );
    end

    tower_keeper #(
        .NUM_SLOTS (NUM_SLOTS),
        .TOWER_HP  (TOWER_HP)
    ) i_tower_keeper (
        .clk_25MHz (clk_25MHz),
        .rst       (rst),
        .tick      (tick),
        .fire      (fire),
        .hit       (hit),
        .hit_dmg   (hit_dmg),
        .repel     (repel),
        .charge    (charge),
        .tower_hp  (tower_hp),
        .game_lose (game_lose)
    );

endmodule

`default_nettype wire

// ==== verilog/tower_keeper.sv ====
`timescale 1ns/1ps
`default_nettype none

module tower_keeper #(
    parameter int          NUM_SLOTS = 8,
    parameter logic [11:0] TOWER_HP  = 12'd4000
) (
    input  logic                 clk_25MHz,
    input  logic                 rst,
    input  logic                 tick,
    input  logic                 fire,
    input  logic [NUM_SLOTS-1:0] hit,
    input  logic [8:0]           hit_dmg [NUM_SLOTS],
    output logic                 repel,
    output logic [7:0]           charge,
    output logic [11:0]          tower_hp,
    output logic                 game_lose
);
    import game_pkg::*;

    localparam int SUM_W = 12 + $clog2(NUM_SLOTS);

    logic [SUM_W-1:0] dmg_sum;
    logic             fire_ok;

    // total damage landing this cycle
    always_comb begin
        dmg_sum = '0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (hit[i]) begin
                dmg_sum = dmg_sum + SUM_W'(hit_dmg[i]);
            end
        end
    end

    assign fire_ok   = fire && (charge == CHARGE_MAX);   // only a full cannon fires
    assign game_lose = (tower_hp == '0);

    always_ff @(posedge clk_25MHz or posedge rst) begin
        if (rst) begin
            tower_hp <= TOWER_HP;
            charge   <= '0;
            repel    <= 1'b0;
        end else begin
            if (dmg_sum >= SUM_W'(tower_hp)) begin
                tower_hp <= '0;   // saturate
            end else begin
                tower_hp <= tower_hp - dmg_sum[11:0];
            end
            repel <= fire_ok;
            if (fire_ok) begin
                charge <= '0;
            end else if (tick && charge < CHARGE_MAX) begin
                charge <= charge + 8'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/unit_slot.sv ====
`timescale 1ns/1ps
`default_nettype none

module unit_slot (
    input  logic                 clk_25MHz,
    input  logic                 rst,
    input  logic                 tick,
    input  logic                 load,
    input  game_pkg::unit_kind_t spawn_kind,
    input  logic                 repel,
    output logic                 alive,
    output logic                 hit,
    output logic [8:0]           hit_dmg
);
    import game_pkg::*;

    unit_kind_t  kind;
    unit_stats_t stats;
    unit_stats_t spawn_stats;
    unit_state_t state;
    unit_state_t state_nxt;
    logic [3:0]  phase;
    logic [3:0]  phase_nxt;
    logic [9:0]  x;
    logic [9:0]  x_nxt;
    logic [11:0] hp;
    logic [11:0] hp_nxt;
    logic        alive_nxt;
    logic        hit_nxt;
    logic        in_range;

    assign stats       = enemy_stats(kind);
    assign spawn_stats = enemy_stats(spawn_kind);
    assign in_range    = ({1'b0, x} + 11'(stats.range)) >= 11'(TOWER_X);

    // --------------------------------------------------
    // next state
    // --------------------------------------------------
    always_comb begin
        alive_nxt = alive;
        state_nxt = state;
        phase_nxt = phase;
        x_nxt     = x;
        hp_nxt    = hp;
        hit_nxt   = 1'b0;
        if (load) begin
            alive_nxt = 1'b1;
            state_nxt = st_move;
            phase_nxt = '0;
            x_nxt     = SPAWN_X;
            hp_nxt    = spawn_stats.hp;
        end else if (repel && alive && x > REPEL_X) begin   // cannon beats tick
            state_nxt = st_repel;
            phase_nxt = '0;
            if (hp <= FIRE_DAMAGE) begin
                alive_nxt = 1'b0;
            end else begin
                hp_nxt = hp - FIRE_DAMAGE;
            end
        end else if (tick && alive) begin
            case (state)
                st_move: begin
                    if (in_range) begin
                        state_nxt = st_atk_0;
                        phase_nxt = '0;
                    end else begin
                        x_nxt = x + 10'(stats.speed);
                    end
                end
                st_atk_0, st_atk_2, st_atk_3: begin
                    if (phase == stats.cooldown) begin
                        phase_nxt = '0;
                        state_nxt = (state == st_atk_0) ? st_atk_1 :
                                    (state == st_atk_2) ? st_atk_3 : st_move;
                    end else begin
                        phase_nxt = phase + 4'd1;
                    end
                end
                st_atk_1: begin
                    hit_nxt   = 1'b1;
                    state_nxt = st_atk_2;
                    phase_nxt = '0;
                end
                st_repel: begin
                    if (phase == REPEL_TICKS) begin
                        state_nxt = st_move;
                        phase_nxt = '0;
                    end else begin
                        phase_nxt = phase + 4'd1;
                        x_nxt     = x - REPEL_STEP;   // pushed back toward spawn
                    end
                end
                default: begin
                    state_nxt = st_move;
                    phase_nxt = '0;
                end
            endcase
        end
    end

    // --------------------------------------------------
    // registers
    // --------------------------------------------------
    always_ff @(posedge clk_25MHz or posedge rst) begin
        if (rst) begin
            alive <= 1'b0;
            state <= st_move;
            phase <= '0;
            hit   <= 1'b0;
        end else begin
            alive <= alive_nxt;
            state <= state_nxt;
            phase <= phase_nxt;
            hit   <= hit_nxt;
        end
    end

    always_ff @(posedge clk_25MHz) begin
        x  <= x_nxt;
        hp <= hp_nxt;
        if (load) begin
            kind <= spawn_kind;
        end
        if (hit_nxt) begin
            hit_dmg <= stats.atk;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/unit_spawner.sv ====
`timescale 1ns/1ps
`default_nettype none

module unit_spawner #(
    parameter int NUM_SLOTS = 8
) (
    input  logic                 spawn,
    input  logic [NUM_SLOTS-1:0] alive,
    output logic [NUM_SLOTS-1:0] load
);

    logic found;

    // lowest free slot wins, spawn dropped when all are taken
    always_comb begin
        load  = '0;
        found = 1'b0;
        if (spawn) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                if (!alive[i] && !found) begin
                    load[i] = 1'b1;
                    found   = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/game_pkg.sv ====
`default_nettype none

package game_pkg;

    // --------------------------------------------------
    // slot state and enemy kinds
    // --------------------------------------------------
    typedef enum logic [2:0] {
        st_move  = 3'd1,
        st_atk_0 = 3'd2,
        st_atk_1 = 3'd3,   // strike phase
        st_atk_2 = 3'd4,
        st_atk_3 = 3'd5,
        st_repel = 3'd6
    } unit_state_t;

    typedef enum logic [1:0] {
        killer_bird = 2'd0,
        white_bear  = 2'd1,
        metal_duck  = 2'd2,
        black_bear  = 2'd3
    } unit_kind_t;

    typedef struct packed {
        logic [11:0] hp;
        logic [8:0]  atk;
        logic [3:0]  cooldown;   // ticks per waiting phase
        logic [4:0]  speed;
        logic [7:0]  range;
    } unit_stats_t;

    function automatic unit_stats_t enemy_stats(input unit_kind_t kind);
        unit_stats_t s;
        case (kind)
            killer_bird: s = '{hp: 12'd200, atk: 9'd40, cooldown: 4'd2, speed: 5'd4, range: 8'd20};
            white_bear:  s = '{hp: 12'd600, atk: 9'd90, cooldown: 4'd4, speed: 5'd2, range: 8'd30};
            metal_duck:  s = '{hp: 12'd900, atk: 9'd60, cooldown: 4'd3, speed: 5'd3, range: 8'd60};
            black_bear:  s = '{hp: 12'd1500, atk: 9'd150, cooldown: 4'd6, speed: 5'd1, range: 8'd25};
            default:     s = '0;
        endcase
        return s;
    endfunction

    // --------------------------------------------------
    // lane geometry and cannon
    // --------------------------------------------------
    localparam logic [9:0]  SPAWN_X     = 10'd10;
    localparam logic [9:0]  TOWER_X     = 10'd570;
    localparam logic [9:0]  REPEL_X     = 10'd250;   // cannon reach
    localparam logic [3:0]  REPEL_TICKS = 4'd10;
    localparam logic [9:0]  REPEL_STEP  = 10'd3;
    localparam logic [11:0] FIRE_DAMAGE = 12'd300;
    localparam logic [7:0]  CHARGE_MAX  = 8'd150;

endpackage

`default_nettype wire
